// File: debug_stim.txt
# kind addr data expect, all hex; R and W compare the response byte with expect
# F is an expected frame buffer request (addr, 16-bit data), listed before its trigger write
W 0123 5a 00
R 0123 00 5a
R 0923 00 5a
R 1923 00 5a
W 6000 ff 00
W 6001 ff 00
W 6002 ff 00
R 6000 00 ff
R 6001 00 ff
R 6002 00 0f
W 6003 11 00
W 6005 ab 00
W 6006 22 00
W 6007 33 00
R 6003 00 11
R 6005 00 ab
R 6006 00 22
R 6007 00 33
F fffff ab01 00
W 6004 01 00
R 6004 00 01
F 00000 ab02 00
W 6004 02 00
F 00001 ab03 00
W 6004 03 00
R 6000 00 02
R 6001 00 00
R 6002 00 00
F 00002 ab10 00
F 00003 ab11 00
F 00004 ab12 00
F 00005 ab13 00
F 00006 ab14 00
F 00007 ab15 00
F 00008 ab16 00
F 00009 ab17 00
F 0000a ab18 00
F 0000b ab19 00
W 6004 10 00
W 6004 11 00
W 6004 12 00
W 6004 13 00
W 6004 14 00
W 6004 15 00
W 6004 16 00
W 6004 17 00
W 6004 18 00
W 6004 19 00
R 6000 00 0c
R 6004 00 19
R 4000 00 ff
R 9000 00 ff
W 4123 77 00
W 2123 66 00
W 9005 55 00
R 0123 00 5a
R 6005 00 ab
R 6007 00 33

// File: sources.f
debug_pkg.sv
debug_ram.sv
fb_port_regs.sv
fb_req_queue.sv
debug_bus_ctrl.sv
debug_top.sv
tb_debug_assertions.sv
tb_debug.sv

// File: tb_debug.sv
`timescale 1ns/1ps

module tb_debug import debug_pkg::*; ();

// One line of the stimulus file
typedef struct packed {
	logic [7:0]  kind;
	logic [19:0] addr;
	logic [15:0] data;
	logic [7:0]  expect_byte;
} stim_entry_t;

logic     clkRAM;
logic     n_reset;
bus_req_t bus_req;
logic     bus_valid;
logic     bus_ready;
bus_rsp_t bus_rsp;
logic     rsp_valid;
fb_req_t  fb_req;
logic     fb_valid;
logic     fb_ready;

stim_entry_t stim[$];
fb_req_t exp_fb[$];
int stim_count = 0;
logic [15:0] lfsr_state = 16'd44082;
// Cycles of forced back-pressure at the start of the long burst
int stall_left = 16;

debug_top dut_i (
	.clkRAM    (clkRAM),
	.n_reset   (n_reset),
	.bus_req   (bus_req),
	.bus_valid (bus_valid),
	.bus_ready (bus_ready),
	.bus_rsp   (bus_rsp),
	.rsp_valid (rsp_valid),
	.fb_req    (fb_req),
	.fb_valid  (fb_valid),
	.fb_ready  (fb_ready)
);

always #10 clkRAM = ~clkRAM;

task automatic abort_run(input string reason);
	$display("%s", reason);
	$display("Test failed");
	$fatal(1, "stopping at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	if (actual !== expected)
		abort_run($sformatf("mismatch %s exp 0x%0h got 0x%0h", name, expected, actual));
endtask

// Taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
	return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

task automatic load_stim();
	int fd;
	int n;
	string line;
	logic [7:0] k;
	logic [31:0] a, d, e;
	stim_entry_t entry;
	fd = $fopen("debug_stim.txt", "r");
	if (fd == 0)
		abort_run("cannot open stimulus file debug_stim.txt");
	while (!$feof(fd)) begin
		line = "";
		if ($fgets(line, fd) == 0)
			break;
		// Skip comments and blank lines
		if (line.len() < 2 || line[0] == "#")
			continue;
		n = $sscanf(line, "%c %h %h %h", k, a, d, e);
		if (n != 4)
			abort_run($sformatf("malformed stimulus line: %s", line));
		entry.kind = k;
		entry.addr = a[19:0];
		entry.data = d[15:0];
		entry.expect_byte = e[7:0];
		stim.push_back(entry);
	end
	$fclose(fd);
	if (stim.size() == 0)
		abort_run("stimulus file holds no accesses");
	stim_count = stim.size();
endtask

// Called at a falling edge, returns at the falling edge of the response cycle
task automatic bus_access(input logic write, input logic [15:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
	bus_req.addr = addr;
	bus_req.wdata = wdata;
	bus_req.write = write;
	bus_valid = 1'b1;
	while (!bus_ready)
		@(negedge clkRAM);
	// Accepted on the rising edge just passed
	@(negedge clkRAM);
	bus_valid = 1'b0;
	while (!rsp_valid)
		@(negedge clkRAM);
	rdata = bus_rsp.rdata;
endtask

initial begin : main
	stim_entry_t entry;
	fb_req_t exp_entry;
	logic [7:0] rdata;
	clkRAM = 1'b0;
	n_reset = 1'b0;
	bus_req = '0;
	bus_valid = 1'b0;
	fb_ready = 1'b0;
	load_stim();
	repeat (2) @(negedge clkRAM);
	n_reset = 1'b1;
	@(negedge clkRAM);
	check_value("bus_ready", 1, bus_ready);
	check_value("rsp_valid", 0, rsp_valid);
	check_value("fb_valid", 0, fb_valid);
	foreach (stim[i]) begin
		entry = stim[i];
		case (entry.kind)
		"F": begin
			exp_entry.addr = entry.addr;
			exp_entry.data = entry.data;
			exp_fb.push_back(exp_entry);
		end
		"R", "W": begin
			bus_access(entry.kind == "W", entry.addr[15:0], entry.data[7:0], rdata);
			check_value("bus_rsp.rdata", entry.expect_byte, rdata);
		end
		default:
			abort_run($sformatf("unknown access kind %c in stimulus file", entry.kind));
		endcase
	end
	// Let the queue drain
	while (fb_valid)
		@(negedge clkRAM);
	if (exp_fb.size() != 0) begin
		abort_run($sformatf("%0d expected frame buffer requests never arrived",
			exp_fb.size()));
	end else begin
		$display("Test completed successfully");
		$finish;
	end
end

// Random back-pressure and in-order compare of the frame buffer stream
always @(negedge clkRAM) begin : fb_sink
	logic bit_a, bit_b;
	fb_req_t expected;
	lfsr_state = lfsr_step(lfsr_state);
	bit_a = lfsr_state[0];
	lfsr_state = lfsr_step(lfsr_state);
	bit_b = lfsr_state[0];
	fb_ready = bit_a | bit_b;
	// Starve the stream early in the long burst so trigger writes meet a full queue
	if (fb_valid && exp_fb.size() > 8 && stall_left > 0) begin
		fb_ready = 1'b0;
		stall_left--;
	end
	// Transfer happens at the next rising edge
	if (fb_valid && fb_ready) begin
		if (exp_fb.size() == 0) begin
			abort_run("frame buffer request arrived that the stimulus does not expect");
		end else begin
			expected = exp_fb.pop_front();
			check_value("fb_req.addr", expected.addr, fb_req.addr);
			check_value("fb_req.data", expected.data, fb_req.data);
		end
	end
end

always @(negedge clkRAM)
	if (dut_i.chk_i.fail_count != 0)
		abort_run("a bound assertion on the DUT interfaces failed");

initial begin : watchdog
	wait (stim_count > 0);
	repeat (stim_count * 20 + 200) @(posedge clkRAM);
	abort_run("timeout, the DUT did not finish the stimulus in time");
end

endmodule

// File: tb_debug_assertions.sv
`timescale 1ns/1ps

module tb_debug_assertions import debug_pkg::*; (
	input logic    clkRAM,
	input logic    n_reset,
	input logic    bus_valid,
	input logic    bus_ready,
	input logic    rsp_valid,
	input fb_req_t fb_req,
	input logic    fb_valid,
	input logic    fb_ready
);

// Number of failed properties
int unsigned fail_count = 0;

// Set from bus acceptance until the response cycle has passed
logic pending;

always_ff @(posedge clkRAM, negedge n_reset)
	if (~n_reset)
		pending <= 1'b0;
	else if (bus_valid && bus_ready)
		pending <= 1'b1;
	else if (rsp_valid)
		pending <= 1'b0;

// Stalled frame buffer request holds
fb_hold: assert property (@(posedge clkRAM) disable iff (!n_reset)
	fb_valid && !fb_ready |=> fb_valid && $stable(fb_req))
	else begin
		$error("fb_req changed or dropped while stalled");
		fail_count++;
	end

// One access outstanding at a time
bus_busy: assert property (@(posedge clkRAM) disable iff (!n_reset)
	pending |-> !bus_ready)
	else begin
		$error("bus_ready high while an access is outstanding");
		fail_count++;
	end

rsp_owned: assert property (@(posedge clkRAM) disable iff (!n_reset)
	rsp_valid |-> pending)
	else begin
		$error("rsp_valid without an accepted access");
		fail_count++;
	end

rsp_pulse: assert property (@(posedge clkRAM) disable iff (!n_reset)
	rsp_valid |=> !rsp_valid)
	else begin
		$error("rsp_valid held for more than one cycle");
		fail_count++;
	end

endmodule

bind debug_top tb_debug_assertions chk_i (
	.clkRAM    (clkRAM),
	.n_reset   (n_reset),
	.bus_valid (bus_valid),
	.bus_ready (bus_ready),
	.rsp_valid (rsp_valid),
	.fb_req    (fb_req),
	.fb_valid  (fb_valid),
	.fb_ready  (fb_ready)
);

// File: debug_top.sv
`timescale 1ns/1ps

module debug_top import debug_pkg::*; (
	input  logic     clkRAM,
	input  logic     n_reset,
	input  bus_req_t bus_req,
	input  logic     bus_valid,
	output logic     bus_ready,
	output bus_rsp_t bus_rsp,
	output logic     rsp_valid,
	output fb_req_t  fb_req,
	output logic     fb_valid,
	input  logic     fb_ready
);

access_op_e op;
logic [15:0] acc_addr;
logic [7:0] acc_wdata;
logic [7:0] ram_rdata, reg_rdata;
logic q_space;
logic push;
fb_req_t push_req;

debug_bus_ctrl ctrl_i (
	.clkRAM    (clkRAM),
	.n_reset   (n_reset),
	.bus_req   (bus_req),
	.bus_valid (bus_valid),
	.bus_ready (bus_ready),
	.bus_rsp   (bus_rsp),
	.rsp_valid (rsp_valid),
	.op        (op),
	.acc_addr  (acc_addr),
	.acc_wdata (acc_wdata),
	.ram_rdata (ram_rdata),
	.reg_rdata (reg_rdata),
	.q_space   (q_space)
);

// Only the low address bits reach the RAM, hence the repetition
debug_ram ram_i (
	.clkRAM (clkRAM),
	.op     (op),
	.addr   (acc_addr[RAM_ADDR_BITS-1:0]),
	.wdata  (acc_wdata),
	.rdata  (ram_rdata)
);

fb_port_regs regs_i (
	.clkRAM   (clkRAM),
	.n_reset  (n_reset),
	.op       (op),
	.offset   (acc_addr[2:0]),
	.wdata    (acc_wdata),
	.rdata    (reg_rdata),
	.push     (push),
	.push_req (push_req)
);

fb_req_queue queue_i (
	.clkRAM   (clkRAM),
	.n_reset  (n_reset),
	.push     (push),
	.push_req (push_req),
	.space    (q_space),
	.fb_req   (fb_req),
	.fb_valid (fb_valid),
	.fb_ready (fb_ready)
);

endmodule

// File: debug_bus_ctrl.sv
`timescale 1ns/1ps

module debug_bus_ctrl import debug_pkg::*; (
	input  logic        clkRAM,
	input  logic        n_reset,
	input  bus_req_t    bus_req,
	input  logic        bus_valid,
	output logic        bus_ready,
	output bus_rsp_t    bus_rsp,
	output logic        rsp_valid,
	output access_op_e  op,
	output logic [15:0] acc_addr,
	output logic [7:0]  acc_wdata,
	input  logic [7:0]  ram_rdata,
	input  logic [7:0]  reg_rdata,
	input  logic        q_space
);

ctrl_state_e state, state_next;
access_op_e dec_op, cur_op;
bus_req_t cur_req;
logic in_ram, in_fb;
logic accept, issue;
logic [7:0] rsp_byte;

// Region and offset decode of the incoming request
always_comb begin
	in_ram = (bus_req.addr & RAM_BASE_MASK) == 16'h0000;
	in_fb = (bus_req.addr & FB_BASE_MASK) == FB_BASE;
	if (in_ram)
		dec_op = bus_req.write ? OP_RAM_WR : OP_RAM_RD;
	else if (in_fb && bus_req.write)
		dec_op = (bus_req.addr[2:0] == FB_TRIGGER_OFFSET) ? OP_FB_PUSH : OP_REG_WR;
	else if (in_fb)
		dec_op = OP_REG_RD;
	else
		dec_op = OP_NONE;
end

// Hold off new requests while the response is still on the bus
assign bus_ready = (state == ST_IDLE) && !rsp_valid;
assign accept = bus_valid && bus_ready;

// A push only goes ahead with a free queue entry
assign issue = (state == ST_ACCESS || state == ST_WAIT) &&
	(cur_op != OP_FB_PUSH || q_space);

assign op = issue ? cur_op : OP_NONE;
assign acc_addr = cur_req.addr;
assign acc_wdata = cur_req.wdata;

always_comb begin
	state_next = state;
	case (state)
	ST_IDLE:
		if (accept)
			state_next = ST_ACCESS;
	ST_ACCESS, ST_WAIT:
		state_next = issue ? ST_RESP : ST_WAIT;
	ST_RESP:
		state_next = ST_IDLE;
	default:
		state_next = ST_IDLE;
	endcase
end

always_ff @(posedge clkRAM, negedge n_reset)
	if (~n_reset) begin
		state <= ST_IDLE;
		cur_op <= OP_NONE;
		rsp_valid <= 1'b0;
	end else begin
		state <= state_next;
		if (accept)
			cur_op <= dec_op;
		rsp_valid <= (state == ST_RESP);
	end

always_ff @(posedge clkRAM)
	if (accept)
		cur_req <= bus_req;

// Response byte source, writes answer with zero
always_comb begin
	case (cur_op)
	OP_RAM_RD:
		rsp_byte = ram_rdata;
	OP_REG_RD:
		rsp_byte = reg_rdata;
	OP_NONE:
		rsp_byte = cur_req.write ? 8'h00 : UNMAPPED_DATA;
	default:
		rsp_byte = 8'h00;
	endcase
end

always_ff @(posedge clkRAM)
	if (state == ST_RESP)
		bus_rsp.rdata <= rsp_byte;

endmodule

// File: fb_req_queue.sv
`timescale 1ns/1ps

module fb_req_queue import debug_pkg::*; (
	input  logic    clkRAM,
	input  logic    n_reset,
	input  logic    push,
	input  fb_req_t push_req,
	output logic    space,
	output fb_req_t fb_req,
	output logic    fb_valid,
	input  logic    fb_ready
);

fb_req_t mem [FB_QUEUE_DEPTH];
logic [$clog2(FB_QUEUE_DEPTH)-1:0] wr_ptr, rd_ptr;
logic [$clog2(FB_QUEUE_DEPTH+1)-1:0] count;
logic pop;

assign fb_valid = (count != 0);
assign fb_req = mem[rd_ptr];
assign pop = fb_valid && fb_ready;

// Registered count keeps q_space free of the fb_ready path
assign space = (count < FB_QUEUE_DEPTH);

always_ff @(posedge clkRAM, negedge n_reset)
	if (~n_reset) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		for (int i = 0; i < FB_QUEUE_DEPTH; i++)
			mem[i] <= '0;
	end else begin
		if (push) begin
			mem[wr_ptr] <= push_req;
			if (wr_ptr == FB_QUEUE_DEPTH - 1)
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
		if (pop) begin
			if (rd_ptr == FB_QUEUE_DEPTH - 1)
				rd_ptr <= '0;
			else
				rd_ptr <= rd_ptr + 1'b1;
		end
		// Simultaneous push and pop leaves the count alone
		if (push && !pop)
			count <= count + 1'b1;
		else if (pop && !push)
			count <= count - 1'b1;
	end

endmodule

// File: fb_port_regs.sv
`timescale 1ns/1ps

module fb_port_regs import debug_pkg::*; (
	input  logic       clkRAM,
	input  logic       n_reset,
	input  access_op_e op,
	input  logic [2:0] offset,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic       push,
	output fb_req_t    push_req
);

// Offsets 0 to 2 address, 4 data low, 5 data high, rest reserved
logic [7:0] regs [8];
logic [FB_ADDR_BITS-1:0] cur_addr, next_addr;

assign cur_addr = {regs[2][3:0], regs[1], regs[0]};
// Wraps at 20 bits
assign next_addr = cur_addr + 1'b1;

assign rdata = regs[offset];

// Request leaves with the address before the increment
assign push = (op == OP_FB_PUSH);
assign push_req.addr = cur_addr;
assign push_req.data = {regs[FB_DATA_HI_OFFSET], wdata};

always_ff @(posedge clkRAM, negedge n_reset)
	if (~n_reset) begin
		for (int i = 0; i < 8; i++)
			regs[i] <= 8'h00;
	end else begin
		case (op)
		OP_REG_WR:
			// Top address byte only keeps its low nibble
			if (offset == 3'd2)
				regs[2] <= {4'h0, wdata[3:0]};
			else
				regs[offset] <= wdata;
		OP_FB_PUSH: begin
			regs[FB_TRIGGER_OFFSET] <= wdata;
			{regs[2], regs[1], regs[0]} <= {4'h0, next_addr};
		end
		default: ;
		endcase
	end

endmodule

// File: debug_ram.sv
`timescale 1ns/1ps

module debug_ram import debug_pkg::*; (
	input  logic                     clkRAM,
	input  access_op_e               op,
	input  logic [RAM_ADDR_BITS-1:0] addr,
	input  logic [7:0]               wdata,
	output logic [7:0]               rdata
);

// 2 kB of byte storage, aliased across the RAM region by the caller
logic [7:0] mem [2**RAM_ADDR_BITS];

always_ff @(posedge clkRAM) begin
	if (op == OP_RAM_WR)
		mem[addr] <= wdata;
	// Read data only moves on a read so it holds for the response
	if (op == OP_RAM_RD)
		rdata <= mem[addr];
end

endmodule

// File: debug_pkg.sv
package debug_pkg;

// Sizes
localparam int RAM_ADDR_BITS = 11;
localparam int FB_ADDR_BITS = 20;
localparam int FB_DATA_BITS = 16;
localparam int FB_QUEUE_DEPTH = 2;

// Address map, compared after masking
localparam logic [15:0] RAM_BASE_MASK = 16'hE000;
localparam logic [15:0] FB_BASE_MASK = 16'hF000;
localparam logic [15:0] FB_BASE = 16'h6000;

// Window offsets
localparam logic [2:0] FB_TRIGGER_OFFSET = 3'd4;
localparam logic [2:0] FB_DATA_HI_OFFSET = 3'd5;

// Read value for holes in the map
localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

// One bus access from the master
typedef struct packed {
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic        write;
} bus_req_t;

typedef struct packed {
	logic [7:0] rdata;
} bus_rsp_t;

// One frame buffer write request
typedef struct packed {
	logic [FB_ADDR_BITS-1:0] addr;
	logic [FB_DATA_BITS-1:0] data;
} fb_req_t;

// Access issued by the controller to the datapath
typedef enum logic [2:0] {
	OP_NONE,
	OP_RAM_RD,
	OP_RAM_WR,
	OP_REG_RD,
	OP_REG_WR,
	OP_FB_PUSH
} access_op_e;

// Controller sequencing
typedef enum logic [1:0] {
	ST_IDLE,
	ST_ACCESS,
	ST_WAIT,
	ST_RESP
} ctrl_state_e;

endpackage
